/* Makefile */
VERILATOR ?= verilator
TOP       ?= hps_io_tb
FILELIST  ?= hps_io.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  := ERRORS FOUND
PASS_MSG  := NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it into $(LOG), search for the fail message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; echo "simulator exit status $$?" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "test failed, no result line"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hps_io.f */
verilog/hps_pkg.sv
verilog/hps_cmd_frame.sv
verilog/hps_core_regs.sv
verilog/hps_file_loader.sv
verilog/hps_status_reply.sv
verilog/hps_io.sv
testbench/hps_io_checker.sv
testbench/hps_io_monitor.sv
testbench/hps_io_tb.sv

/* testbench/hps_io_checker.sv */
// Assertions bound into the HPS port top level: one-cycle ioctl strobes, quiet outputs in reset
`timescale 1ns/1ns
`default_nettype none

module hps_io_checker
	import hps_pkg::*;
(
	input wire                  clk_sys,
	input wire                  rst_n,
	input wire                  ioctl_wr,
	input wire                  ioctl_rd,
	input wire                  ioctl_download,
	input wire                  ioctl_upload,
	input wire [HPS_WORD_W-1:0] hps_dout
);

	// read by the testbench top at the end of the run
	int fail_count = 0;

	wr_one_cycle: assert property (@(posedge clk_sys) ioctl_wr |=> !ioctl_wr)
		else begin
			$error("ioctl_wr held high for more than one cycle");
			fail_count++;
		end

	rd_one_cycle: assert property (@(posedge clk_sys) ioctl_rd |=> !ioctl_rd)
		else begin
			$error("ioctl_rd held high for more than one cycle");
			fail_count++;
		end

	// synchronous reset, so outputs settle one edge later
	quiet_in_reset: assert property (@(posedge clk_sys) !rst_n |=>
			(!ioctl_wr && !ioctl_rd && !ioctl_download && !ioctl_upload && hps_dout == '0))
		else begin
			$error("control outputs not low while reset is held");
			fail_count++;
		end

endmodule

`default_nettype wire

/* testbench/hps_io_monitor.sv */
// Testbench monitor: watches the HPS port outputs and compares them with expected values
`timescale 1ns/1ns
`default_nettype none

module hps_io_monitor
	import hps_pkg::*;
(
	input wire                    clk_sys,
	input wire [HPS_WORD_W-1:0]   hps_dout,
	input wire [31:0]             joystick_0,
	input wire [31:0]             joystick_1,
	input wire [1:0]              buttons,
	input wire                    forced_scandoubler,
	input wire                    direct_video,
	input wire [STATUS_W-1:0]     status,
	input wire                    ioctl_download,
	input wire                    ioctl_upload,
	input wire [15:0]             ioctl_index,
	input wire [31:0]             ioctl_file_ext,
	input wire                    ioctl_wr,
	input wire                    ioctl_rd,
	input wire [IOCTL_ADDR_W-1:0] ioctl_addr,
	input wire [IOCTL_DATA_W-1:0] ioctl_dout
);

	int checks = 0;
	int errors = 0;
	int writes_seen = 0;
	int reads_seen = 0;

	// pending download writes, oldest first
	logic [IOCTL_ADDR_W-1:0] exp_addr_q[$];
	logic [IOCTL_DATA_W-1:0] exp_data_q[$];

	task automatic compare(input string name, input logic [STATUS_W-1:0] got,
			input logic [STATUS_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	// reply word, sampled on the falling edge before the next strobe
	task automatic check_reply(input logic [HPS_WORD_W-1:0] exp);
		@(negedge clk_sys);
		compare("hps_dout", hps_dout, exp);
	endtask

	task automatic check_regs(
		input logic [31:0]             joy0,
		input logic [31:0]             joy1,
		input logic [1:0]              btn,
		input logic                    scandbl,
		input logic                    direct,
		input logic [STATUS_W-1:0]     stat,
		input logic [15:0]             index,
		input logic [31:0]             ext,
		input logic                    download,
		input logic                    upload,
		input logic [IOCTL_ADDR_W-1:0] addr,
		input int                      reads
	);
		@(negedge clk_sys);
		compare("joystick_0", joystick_0, joy0);
		compare("joystick_1", joystick_1, joy1);
		compare("buttons", buttons, btn);
		compare("forced_scandoubler", forced_scandoubler, scandbl);
		compare("direct_video", direct_video, direct);
		compare("status", status, stat);
		compare("ioctl_index", ioctl_index, index);
		compare("ioctl_file_ext", ioctl_file_ext, ext);
		compare("ioctl_download", ioctl_download, download);
		compare("ioctl_upload", ioctl_upload, upload);
		compare("ioctl_addr", ioctl_addr, addr);
		compare("ioctl_rd pulse count", reads_seen, reads);
	endtask

	function automatic void expect_write(input logic [IOCTL_ADDR_W-1:0] addr,
			input logic [IOCTL_DATA_W-1:0] value);
		exp_addr_q.push_back(addr);
		exp_data_q.push_back(value);
	endfunction

	task automatic check_pending();
		if (exp_addr_q.size() != 0) begin
			errors++;
			$display("%0d expected ioctl_wr pulses never arrived", exp_addr_q.size());
		end
	endtask

	////////////////////
	// write pulses
	////////////////////

	always @(negedge clk_sys) begin
		if (ioctl_wr) begin
			if (exp_addr_q.size() == 0) begin
				errors++;
				$display("unexpected ioctl_wr pulse at %0t ns, address %0h", $time, ioctl_addr);
			end else begin
				compare("ioctl_addr", ioctl_addr, exp_addr_q.pop_front());
				compare("ioctl_dout", ioctl_dout, exp_data_q.pop_front());
			end
			writes_seen++;
		end
	end

	// read pulses, one per upload byte request
	always @(negedge clk_sys) begin
		if (ioctl_rd)
			reads_seen++;
	end

endmodule

`default_nettype wire

/* testbench/hps_io_tb.sv */
// Testbench top for the HPS command port; sends a table of host frames and reports the result
`timescale 1ns/1ns
`default_nettype none

module hps_io_tb
	import hps_pkg::*;
;

	localparam int NUM_FRAMES = 13;
	localparam int NUM_WORDS  = 54;
	localparam int WAIT_LIMIT = 50;

	////////////////////
	// frame table
	////////////////////

	// 1 for the file channel, 0 for user I/O
	localparam bit FRAME_FP [NUM_FRAMES] = '{0, 0, 0, 0, 0, 1, 1, 1, 1, 1, 1, 1, 1};
	localparam int FRAME_LEN [NUM_FRAMES] = '{3, 4, 3, 11, 9, 2, 3, 4, 5, 2, 2, 4, 2};

	localparam logic [15:0] FRAME_WORDS [NUM_WORDS] = '{
		16'h0002, 16'h1234, 16'h5678,
		16'h0003, 16'h4321, 16'h8765, 16'hCAFE,
		16'h0001, 16'h0012, 16'h0413,
		// status write, last two words fall off the end
		16'h001E, 16'h0A01, 16'h0A02, 16'h0A03, 16'h0A04, 16'h0A05,
		16'h0A06, 16'h0A07, 16'h0A08, 16'hFFFF, 16'hEEEE,
		16'h0029, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
		16'h0000, 16'h0000, 16'h0000, 16'h0000,
		// index, extension, download at 100h
		16'h0055, 16'h0007,
		16'h0056, 16'h524F, 16'h4D00,
		16'h0053, 16'h0001, 16'h0100, 16'h0000,
		16'h0054, 16'h0011, 16'h0022, 16'h0033, 16'h0044,
		16'h0053, 16'h0000,
		// upload of three bytes
		16'h0053, 16'h00AA,
		16'h0054, 16'h0000, 16'h0000, 16'h0000,
		16'h0053, 16'h0000
	};

	// reply to each word above, same layout
	localparam logic [15:0] FRAME_REPLY [NUM_WORDS] = '{
		16'h0000, 16'h0000, 16'h0000,
		16'h0000, 16'h0000, 16'h0000, 16'h0000,
		16'h0000, 16'h0000, 16'h0000,
		16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
		16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
		16'h00A2, 16'h1111, 16'h2222, 16'h3333, 16'h4444,
		16'h5555, 16'h6666, 16'h7777, 16'h8888,
		16'h0000, 16'h0000,
		16'h0000, 16'h0000, 16'h0000,
		16'h0000, 16'h0000, 16'h0000, 16'h0000,
		16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
		16'h0000, 16'h0000,
		16'h0000, 16'h0000,
		16'h0000, 16'h00A5, 16'h00A4, 16'h00A7,
		16'h00A7, 16'h00A7
	};

	logic                    clk_sys;
	logic                    rst_n;
	logic                    io_strobe;
	logic                    io_enable;
	logic                    fp_enable;
	logic [HPS_WORD_W-1:0]   io_din;
	logic [STATUS_W-1:0]     status_in;
	logic                    status_set;
	logic [IOCTL_DATA_W-1:0] ioctl_din;
	wire  [HPS_WORD_W-1:0]   hps_dout;
	wire  [31:0]             joystick_0;
	wire  [31:0]             joystick_1;
	wire  [1:0]              buttons;
	wire                     forced_scandoubler;
	wire                     direct_video;
	wire  [STATUS_W-1:0]     status;
	wire                     ioctl_download;
	wire                     ioctl_upload;
	wire  [15:0]             ioctl_index;
	wire  [31:0]             ioctl_file_ext;
	wire                     ioctl_wr;
	wire                     ioctl_rd;
	wire  [IOCTL_ADDR_W-1:0] ioctl_addr;
	wire  [IOCTL_DATA_W-1:0] ioctl_dout;

	// expected register state
	logic [31:0]             e_joy0 = '0;
	logic [31:0]             e_joy1 = '0;
	logic [1:0]              e_buttons = '0;
	logic                    e_scandbl = 1'b0;
	logic                    e_direct = 1'b0;
	logic [STATUS_W-1:0]     e_status = '0;
	logic [15:0]             e_index = '0;
	logic [31:0]             e_ext = '0;
	logic                    e_download = 1'b0;
	logic                    e_upload = 1'b0;
	logic [IOCTL_ADDR_W-1:0] e_addr = '0;
	int                      e_reads = 0;
	int                      timeouts = 0;

	hps_io dut_i (.*);

	hps_io_monitor mon_i (.*);

	bind hps_io hps_io_checker checker_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// upload source byte for a given file address
	function automatic logic [IOCTL_DATA_W-1:0] din_for(input logic [IOCTL_ADDR_W-1:0] addr);
		return addr[7:0] ^ 8'hA5;
	endfunction

	always @(posedge clk_sys) begin
		#1;
		ioctl_din = din_for(ioctl_addr);
	end

	task automatic send_word(input logic [HPS_WORD_W-1:0] word);
		@(posedge clk_sys);
		#1;
		io_din    = word;
		io_strobe = 1'b1;
		@(posedge clk_sys);
		#1;
		io_strobe = 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic run_frame(input int f, input int base);
		@(posedge clk_sys);
		#1;
		io_enable = !FRAME_FP[f];
		fp_enable = FRAME_FP[f];
		for (int w = 0; w < FRAME_LEN[f]; w++) begin
			send_word(FRAME_WORDS[base + w]);
			mon_i.check_reply(FRAME_REPLY[base + w]);
		end
		@(posedge clk_sys);
		#1;
		io_enable = 1'b0;
		fp_enable = 1'b0;
		repeat (2) @(posedge clk_sys);
		#1;
	endtask

	task automatic pulse_status_set(input logic [STATUS_W-1:0] value);
		@(posedge clk_sys);
		#1;
		status_in  = value;
		status_set = 1'b1;
		@(posedge clk_sys);
		#1;
		status_set = 1'b0;
	endtask

	task automatic wait_writes(input int n);
		int cycles;
		cycles = 0;
		while (mon_i.writes_seen < n && cycles < WAIT_LIMIT) begin
			@(posedge clk_sys);
			#1;
			cycles++;
		end
		if (mon_i.writes_seen < n) begin
			timeouts++;
			$display("timed out waiting for %0d ioctl_wr pulses", n);
		end
	endtask

	task automatic wait_download_low();
		int cycles;
		cycles = 0;
		while (ioctl_download && cycles < WAIT_LIMIT) begin
			@(posedge clk_sys);
			#1;
			cycles++;
		end
		if (ioctl_download) begin
			timeouts++;
			$display("ioctl_download still high after %0d cycles", WAIT_LIMIT);
		end
	endtask

	task automatic check_state();
		mon_i.check_regs(e_joy0, e_joy1, e_buttons, e_scandbl, e_direct, e_status,
			e_index, e_ext, e_download, e_upload, e_addr, e_reads);
	endtask

	// register state once frame f has finished
	task automatic update_expected(input int f);
		case (f)
			0: e_joy0 = 32'h5678_1234;
			1: e_joy1 = 32'hCAFE_4321;
			2: begin
				e_buttons = 2'b11;
				e_scandbl = 1'b1;
				e_direct  = 1'b1;
			end
			3: e_status = 128'h0A08_0A07_0A06_0A05_0A04_0A03_0A02_0A01;
			5: e_index = 16'h0007;
			6: e_ext = 32'h524F_4D00;
			7: begin
				e_download = 1'b1;
				e_addr     = 27'h100;
				mon_i.expect_write(27'h100, 8'h11);
				mon_i.expect_write(27'h101, 8'h22);
				mon_i.expect_write(27'h102, 8'h33);
				mon_i.expect_write(27'h103, 8'h44);
			end
			8: begin
				e_addr = 27'h103;
				wait_writes(4);
			end
			9: begin
				// next free address stays visible
				e_download = 1'b0;
				e_addr     = 27'h104;
				wait_download_low();
			end
			10: begin
				// upload start requests the first byte
				e_upload = 1'b1;
				e_addr   = '0;
				e_reads  = 1;
			end
			11: begin
				e_addr  = 27'd3;
				e_reads = 4;
			end
			12: e_upload = 1'b0;
			default: ;
		endcase
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin
		int base;
		int total;
		rst_n      = 1'b0;
		io_strobe  = 1'b0;
		io_enable  = 1'b0;
		fp_enable  = 1'b0;
		io_din     = '0;
		status_in  = '0;
		status_set = 1'b0;
		ioctl_din  = '0;
		repeat (2) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;

		mon_i.check_reply(16'h0000);
		check_state();

		// two set requests, only the second value is kept
		pulse_status_set(128'hDEAD_BEEF_DEAD_BEEF_DEAD_BEEF_DEAD_BEEF);
		pulse_status_set(128'h8888_7777_6666_5555_4444_3333_2222_1111);
		status_in = '1;

		base = 0;
		for (int f = 0; f < NUM_FRAMES; f++) begin
			run_frame(f, base);
			base += FRAME_LEN[f];
			update_expected(f);
			check_state();
		end
		mon_i.check_pending();

		total = mon_i.errors + timeouts + dut_i.checker_i.fail_count;
		$display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
			mon_i.checks, mon_i.errors, dut_i.checker_i.fail_count, timeouts);
		if (total == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/hps_cmd_frame.sv */
// Host input stage: latches the command word of each frame and tags every following word
`timescale 1ns/1ns
`default_nettype none

module hps_cmd_frame
	import hps_pkg::*;
(
	input  wire                    clk_sys,
	input  wire                    rst_n,
	input  wire                    io_strobe,
	input  wire                    io_enable,
	input  wire                    fp_enable,
	input  wire [HPS_WORD_W-1:0]   io_din,
	output logic [HPS_WORD_W-1:0]  cmd,
	output logic [WORD_IDX_W-1:0]  word_idx,
	output logic                   uio_word,
	output logic                   fio_word,
	output logic                   fp_active,
	output logic [HPS_WORD_W-1:0]  data
);

	// index the next strobe will carry
	logic [WORD_IDX_W-1:0] next_idx;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cmd       <= CMD_NONE;
			word_idx  <= '0;
			next_idx  <= '0;
			uio_word  <= 1'b0;
			fio_word  <= 1'b0;
			fp_active <= 1'b0;
		end else begin
			uio_word  <= 1'b0;
			fio_word  <= 1'b0;
			fp_active <= fp_enable;

			if (!io_enable && !fp_enable) begin
				// no frame open, start over
				cmd      <= CMD_NONE;
				word_idx <= '0;
				next_idx <= '0;
			end else if (io_strobe) begin
				word_idx <= next_idx;
				if (next_idx != '1)
					next_idx <= next_idx + 1'b1;
				// first word of the frame is the opcode
				if (next_idx == '0)
					cmd <= io_din;
				uio_word <= io_enable;
				fio_word <= fp_enable;
			end
		end
	end

	// word payload, aligned with the pulses above
	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			data <= '0;
		else if (io_strobe)
			data <= io_din;
	end

endmodule

`default_nettype wire

/* verilog/hps_core_regs.sv */
// Core-side registers written by the host: joysticks, configuration word and 128-bit status
`timescale 1ns/1ns
`default_nettype none

module hps_core_regs
	import hps_pkg::*;
(
	input  wire                    clk_sys,
	input  wire                    rst_n,
	input  wire [HPS_WORD_W-1:0]   cmd,
	input  wire [WORD_IDX_W-1:0]   word_idx,
	input  wire                    uio_word,
	input  wire [HPS_WORD_W-1:0]   data,
	output logic [31:0]            joystick_0,
	output logic [31:0]            joystick_1,
	output logic [1:0]             buttons,
	output logic                   forced_scandoubler,
	output logic                   direct_video,
	output logic [STATUS_W-1:0]    status
);

	logic [HPS_WORD_W-1:0] cfg;
	logic [WORD_IDX_W-1:0] slice;

	// status slice 0 is carried by data word 1
	assign slice = word_idx - 1'b1;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			joystick_0 <= '0;
			joystick_1 <= '0;
			cfg        <= '0;
			status     <= '0;
		end else if (uio_word && word_idx != '0) begin
			case (cmd)
				CMD_CFG: cfg <= data;
				CMD_JOY0: begin
					if (word_idx == 'd1)
						joystick_0[15:0] <= data;
					else
						joystick_0[31:16] <= data;
				end
				CMD_JOY1: begin
					if (word_idx == 'd1)
						joystick_1[15:0] <= data;
					else
						joystick_1[31:16] <= data;
				end
				CMD_STATUS: begin
					// words past the last slice are dropped
					if (word_idx <= STATUS_WORDS)
						status[slice*HPS_WORD_W +: HPS_WORD_W] <= data;
				end
				default: ;
			endcase
		end
	end

	////////////////////
	// config decode
	////////////////////

	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[CFG_SCANDBL_BIT];
	assign direct_video       = cfg[CFG_DIRECT_BIT];

endmodule

`default_nettype wire

/* verilog/hps_file_loader.sv */
// File-I/O engine: index, extension, and the download/upload byte streams toward the core
`timescale 1ns/1ns
`default_nettype none

module hps_file_loader
	import hps_pkg::*;
(
	input  wire                      clk_sys,
	input  wire                      rst_n,
	input  wire [HPS_WORD_W-1:0]     cmd,
	input  wire [WORD_IDX_W-1:0]     word_idx,
	input  wire                      fio_word,
	input  wire [HPS_WORD_W-1:0]     data,
	input  wire [IOCTL_DATA_W-1:0]   ioctl_din,
	output logic                     ioctl_download,
	output logic                     ioctl_upload,
	output logic [15:0]              ioctl_index,
	output logic [31:0]              ioctl_file_ext,
	output logic                     ioctl_wr,
	output logic                     ioctl_rd,
	output logic [IOCTL_ADDR_W-1:0]  ioctl_addr,
	output logic [IOCTL_DATA_W-1:0]  ioctl_dout,
	output logic [HPS_WORD_W-1:0]    fp_dout
);

	// download write pointer, runs one byte ahead of ioctl_addr
	logic [IOCTL_ADDR_W-1:0] addr;
	// write request, delayed one cycle into ioctl_wr
	logic                    wr_q;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ioctl_download <= 1'b0;
			ioctl_upload   <= 1'b0;
			ioctl_index    <= '0;
			ioctl_file_ext <= '0;
			ioctl_wr       <= 1'b0;
			ioctl_rd       <= 1'b0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
			fp_dout        <= '0;
			addr           <= '0;
			wr_q           <= 1'b0;
		end else begin
			ioctl_wr <= wr_q;
			wr_q     <= 1'b0;
			ioctl_rd <= 1'b0;

			if (fio_word && word_idx != '0) begin
				case (cmd)
					FIO_FILE_INDEX: ioctl_index <= data;

					FIO_FILE_INFO: begin
						// extension arrives high half first
						if (word_idx == 'd1)
							ioctl_file_ext[31:16] <= data;
						else if (word_idx == 'd2)
							ioctl_file_ext[15:0] <= data;
					end

					FIO_FILE_TX: begin
						case (word_idx)
							'd1: begin
								if (data[7:0] == UPLOAD_MAGIC) begin
									ioctl_addr   <= '0;
									ioctl_upload <= 1'b1;
									ioctl_rd     <= 1'b1;
								end else if (data[7:0] != 8'h00) begin
									addr           <= '0;
									ioctl_download <= 1'b1;
								end else begin
									// end of transfer, expose next free address
									if (ioctl_download)
										ioctl_addr <= addr;
									ioctl_download <= 1'b0;
									ioctl_upload   <= 1'b0;
								end
							end
							'd2: begin
								ioctl_addr[HPS_WORD_W-1:0] <= data;
								addr[HPS_WORD_W-1:0]       <= data;
							end
							'd3: begin
								ioctl_addr[IOCTL_ADDR_W-1:HPS_WORD_W] <=
									data[IOCTL_ADDR_W-HPS_WORD_W-1:0];
								addr[IOCTL_ADDR_W-1:HPS_WORD_W] <=
									data[IOCTL_ADDR_W-HPS_WORD_W-1:0];
							end
							default: ;
						endcase
					end

					FIO_FILE_TX_DAT: begin
						if (ioctl_download) begin
							ioctl_addr <= addr;
							ioctl_dout <= data[IOCTL_DATA_W-1:0];
							wr_q       <= 1'b1;
							addr       <= addr + 1'b1;
						end else if (ioctl_upload) begin
							// byte read for the previous address goes back to the host
							fp_dout    <= {{(HPS_WORD_W-IOCTL_DATA_W){1'b0}}, ioctl_din};
							ioctl_addr <= ioctl_addr + 1'b1;
							ioctl_rd   <= 1'b1;
						end
					end

					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/hps_io.sv */
// Top level of the reduced HPS command port; connects framing, registers, loader and reply
`timescale 1ns/1ns
`default_nettype none

module hps_io
	import hps_pkg::*;
(
	input  wire                      clk_sys,
	input  wire                      rst_n,

	// host word bus
	input  wire                      io_strobe,
	input  wire                      io_enable,
	input  wire                      fp_enable,
	input  wire [HPS_WORD_W-1:0]     io_din,
	output wire [HPS_WORD_W-1:0]     hps_dout,

	// core controls
	output wire [31:0]               joystick_0,
	output wire [31:0]               joystick_1,
	output wire [1:0]                buttons,
	output wire                      forced_scandoubler,
	output wire                      direct_video,
	output wire [STATUS_W-1:0]       status,
	input  wire [STATUS_W-1:0]       status_in,
	input  wire                      status_set,

	// file channel
	output wire                      ioctl_download,
	output wire                      ioctl_upload,
	output wire [15:0]               ioctl_index,
	output wire [31:0]               ioctl_file_ext,
	output wire                      ioctl_wr,
	output wire                      ioctl_rd,
	output wire [IOCTL_ADDR_W-1:0]   ioctl_addr,
	output wire [IOCTL_DATA_W-1:0]   ioctl_dout,
	input  wire [IOCTL_DATA_W-1:0]   ioctl_din
);

	wire [HPS_WORD_W-1:0] cmd;
	wire [WORD_IDX_W-1:0] word_idx;
	wire                  uio_word;
	wire                  fio_word;
	wire                  fp_active;
	wire [HPS_WORD_W-1:0] data;
	wire [HPS_WORD_W-1:0] fp_dout;

	hps_cmd_frame frame_i (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.io_strobe (io_strobe),
		.io_enable (io_enable),
		.fp_enable (fp_enable),
		.io_din    (io_din),
		.cmd       (cmd),
		.word_idx  (word_idx),
		.uio_word  (uio_word),
		.fio_word  (fio_word),
		.fp_active (fp_active),
		.data      (data)
	);

	hps_core_regs regs_i (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.cmd                (cmd),
		.word_idx           (word_idx),
		.uio_word           (uio_word),
		.data               (data),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.status             (status)
	);

	hps_file_loader loader_i (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.cmd            (cmd),
		.word_idx       (word_idx),
		.fio_word       (fio_word),
		.data           (data),
		.ioctl_din      (ioctl_din),
		.ioctl_download (ioctl_download),
		.ioctl_upload   (ioctl_upload),
		.ioctl_index    (ioctl_index),
		.ioctl_file_ext (ioctl_file_ext),
		.ioctl_wr       (ioctl_wr),
		.ioctl_rd       (ioctl_rd),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.fp_dout        (fp_dout)
	);

	hps_status_reply reply_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.cmd        (cmd),
		.word_idx   (word_idx),
		.uio_word   (uio_word),
		.fp_active  (fp_active),
		.fp_dout    (fp_dout),
		.status_in  (status_in),
		.status_set (status_set),
		.hps_dout   (hps_dout)
	);

endmodule

`default_nettype wire

/* verilog/hps_pkg.sv */
// Shared opcodes, widths and bit positions for the HPS command port; imported by every RTL block
`default_nettype none

package hps_pkg;

	////////////////////
	// bus geometry
	////////////////////

	localparam int HPS_WORD_W   = 16;
	// word counter saturates at 15
	localparam int WORD_IDX_W   = 4;
	localparam int STATUS_W     = 128;
	localparam int STATUS_WORDS = 8;
	localparam int IOCTL_ADDR_W = 27;
	localparam int IOCTL_DATA_W = 8;

	// first TX data byte that selects an upload
	localparam logic [7:0] UPLOAD_MAGIC     = 8'hAA;
	// high nibble of the status-get reply
	localparam logic [3:0] STATUS_REPLY_TAG = 4'hA;

	// configuration word fields
	localparam int CFG_SCANDBL_BIT = 4;
	localparam int CFG_DIRECT_BIT  = 10;

	////////////////////
	// opcodes
	////////////////////

	// user-I/O commands
	typedef enum logic [15:0] {
		CMD_NONE       = 16'h0000,
		CMD_CFG        = 16'h0001,
		CMD_JOY0       = 16'h0002,
		CMD_JOY1       = 16'h0003,
		CMD_STATUS     = 16'h001E,
		CMD_STATUS_GET = 16'h0029
	} hps_cmd_e;

	// file-I/O commands
	typedef enum logic [15:0] {
		FIO_FILE_TX     = 16'h0053,
		FIO_FILE_TX_DAT = 16'h0054,
		FIO_FILE_INDEX  = 16'h0055,
		FIO_FILE_INFO   = 16'h0056
	} fio_cmd_e;

endpackage

`default_nettype wire

/* verilog/hps_status_reply.sv */
// Host output stage: status-set tracking and the registered reply word returned to the host
`timescale 1ns/1ns
`default_nettype none

module hps_status_reply
	import hps_pkg::*;
(
	input  wire                    clk_sys,
	input  wire                    rst_n,
	input  wire [HPS_WORD_W-1:0]   cmd,
	input  wire [WORD_IDX_W-1:0]   word_idx,
	input  wire                    uio_word,
	input  wire                    fp_active,
	input  wire [HPS_WORD_W-1:0]   fp_dout,
	input  wire [STATUS_W-1:0]     status_in,
	input  wire                    status_set,
	output logic [HPS_WORD_W-1:0]  hps_dout
);

	logic                  status_set_q;
	logic [3:0]            req_cnt;
	logic [STATUS_W-1:0]   status_req;
	logic [HPS_WORD_W-1:0] uio_dout;
	logic [WORD_IDX_W-1:0] slice;

	assign slice = word_idx - 1'b1;

	////////////////////
	// set requests
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			status_set_q <= 1'b0;
			req_cnt      <= '0;
			status_req   <= '0;
		end else begin
			status_set_q <= status_set;
			if (status_set && !status_set_q) begin
				req_cnt    <= req_cnt + 1'b1;
				status_req <= status_in;
			end
		end
	end

	////////////////////
	// reply word
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			uio_dout <= '0;
		end else if (uio_word) begin
			uio_dout <= '0;
			if (cmd == CMD_STATUS_GET) begin
				if (word_idx == '0)
					uio_dout <= {8'h00, STATUS_REPLY_TAG, req_cnt};
				else if (word_idx <= STATUS_WORDS)
					uio_dout <= status_req[slice*HPS_WORD_W +: HPS_WORD_W];
			end
		end else if (cmd == CMD_NONE) begin
			// cmd reads CMD_NONE between frames
			uio_dout <= '0;
		end
	end

	// file channel owns the bus while its frame is open
	assign hps_dout = fp_active ? fp_dout : uio_dout;

endmodule

`default_nettype wire
